/* build.f */
+incdir+include
source/snow_pkg.sv
source/key_tracker.sv
source/block_collision.sv
source/player_motion.sv
source/pickup_tracker.sv
source/snow_game_top.sv
test/tb_clock.sv
test/snow_game_tb.sv

/* test/snow_game_tb.sv */
`include "snow_consts.svh"

module snow_game_tb
    import snow_pkg::*;
();

    localparam int move_period = `SNOW_TICK_CYCLES * `SNOW_MOVE_TICKS;
    localparam int walk_far = 150;
    localparam int walk_back = 90;
    // reset, walk, jump, three walks over the flakes, respawn, plus a margin
    localparam int limit_cycles = 16 + 17 * move_period + 400 * `SNOW_TICK_CYCLES
        + 3 * (walk_far + 10) * move_period + 8 * `SNOW_TICK_CYCLES + 1000;

    logic                       clk;
    logic                       rst;
    logic                       key_valid;
    logic                       key_ready;
    key_event_t                 key_event;
    pos_t                       player_pos;
    motion_state_e              motion;
    logic [3:0]                 score;
    logic [`SNOW_FLAKE_NUM-1:0] flakes;
    logic [`SNOW_FLAKE_NUM-1:0] seen_mask;
    logic [31:0]                lfsr;
    int                         errors;
    int                         tests_run;
    int                         tests_failed;

    tb_clock clk_gen (.clk_o(clk));

    snow_game_top dut0 (
        .clk          (clk),
        .rst_i        (rst),
        .key_event_i  (key_event),
        .key_valid_i  (key_valid),
        .key_ready_o  (key_ready),
        .player_pos_o (player_pos),
        .motion_o     (motion),
        .score_o      (score),
        .flakes_o     (flakes)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic is_game_key(input logic [7:0] c);
        return c == 8'h1D || c == 8'h1C || c == 8'h1B || c == 8'h23 || c == 8'h2D;
    endfunction

    // whole pixels moved sideways while a key is held
    function automatic int walk_steps(input int hold_cycles);
        return hold_cycles / move_period;
    endfunction

    // pixels risen before the interval reaches the end value
    function automatic int peak_rise();
        int interval;
        int rise;
        interval = `SNOW_JUMP_START;
        rise = 0;
        while (interval < `SNOW_JUMP_END) begin
            rise += `SNOW_ACCEL_PIXELS;
            interval += `SNOW_ACCEL_STEP;
        end
        return rise;
    endfunction

    // flakes sit in one column at x 144, one every 26 rows
    function automatic logic [`SNOW_FLAKE_NUM-1:0] flake_hits(input int x, input int y);
        logic [`SNOW_FLAKE_NUM-1:0] m;
        int fy;
        m = '0;
        for (int i = 0; i < `SNOW_FLAKE_NUM; i++) begin
            fy = 26 * i;
            m[i] = (x <= 144 + `SNOW_FLAKE_W - 1) && (x + `SNOW_PLAYER_W - 1 >= 144)
                && (y <= fy + `SNOW_FLAKE_H - 1) && (y + `SNOW_PLAYER_H - 1 >= fy);
        end
        return m;
    endfunction

    function automatic int count_ones(input logic [`SNOW_FLAKE_NUM-1:0] m);
        int n;
        n = 0;
        for (int i = 0; i < `SNOW_FLAKE_NUM; i++)
            n += int'(m[i]);
        return n;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_range(input string name, input int lo, input int hi,
                               input int actual);
        assert (actual >= lo && actual <= hi) else begin
            $display("FAILED %s: expected %0d to %0d, actual %0d", name, lo, hi, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_key(input logic [7:0] code, input logic is_release);
        int guard;
        guard = 0;
        key_event.code = code;
        key_event.is_release = is_release;
        key_valid = 1'b1;
        while (!key_ready && guard < 4 * `SNOW_TICK_CYCLES) begin
            @(negedge clk);
            guard++;
        end
        assert (key_ready) else begin
            $display("key event %h was never accepted", code);
            errors++;
        end
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic walk_to(input logic [7:0] code, input int target);
        int guard;
        int limit;
        int diff;
        guard = 0;
        diff = target - int'(player_pos.x);
        limit = ((diff < 0 ? -diff : diff) + 4) * move_period;
        send_key(code, 1'b0);
        while (guard < limit) begin
            if (code == key_right ? int'(player_pos.x) >= target
                                  : int'(player_pos.x) <= target)
                break;
            @(negedge clk);
            guard++;
        end
        assert (guard < limit) else begin
            $display("player did not reach x %0d in time", target);
            errors++;
        end
        send_key(code, 1'b1);
    endtask

    // outputs seen at a rising edge still hold the previous cycle's values
    always @(posedge clk) begin
        if (rst) begin
            seen_mask = '0;
        end else begin
            check_value("flake mask", int'(seen_mask), int'(flakes));
            check_value("score", count_ones(seen_mask), int'(score));
            seen_mask = seen_mask | flake_hits(player_pos.x, player_pos.y);
        end
    end

    initial begin
        int   k;
        int   code;
        int   x_start;
        int   x_stop;
        int   min_y;
        int   guard;
        int   errs;
        int   first_score;
        logic saw_falling;
        lfsr = 32'h4355_af5b;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        key_valid = 1'b0;
        key_event = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        errs = errors;
        check_value("reset x", `SNOW_SPAWN_X, player_pos.x);
        check_value("reset y", `SNOW_SPAWN_Y, player_pos.y);
        check_value("reset motion", int'(on_ground), int'(motion));
        check_value("reset score", 0, score);
        check_value("reset flakes", 0, int'(flakes));
        check_value("reset ready", 1, key_ready);
        report_test("reset values", errs);

        errs = errors;
        draw_bits(3, k);
        k = k + 4;
        draw_bits(8, code);
        while (is_game_key(8'(code)))
            draw_bits(8, code);
        x_start = player_pos.x;
        send_key(key_right, 1'b0);
        repeat (8 * k) @(negedge clk);
        // a foreign release halfway must leave the right flag set
        send_key(8'(code), 1'b1);
        repeat (8 * k - 2) @(negedge clk);
        send_key(key_right, 1'b1);
        repeat (2 * `SNOW_TICK_CYCLES) @(negedge clk);
        x_stop = player_pos.x;
        check_range("walk right distance", walk_steps(move_period * k) - 1,
                    walk_steps(move_period * k), x_stop - x_start);
        check_value("walk y", `SNOW_SPAWN_Y, player_pos.y);
        check_value("walk motion", int'(on_ground), int'(motion));
        repeat (2 * move_period) @(negedge clk);
        check_range("x after release", x_start + walk_steps(move_period * k) - 1,
                    x_start + walk_steps(move_period * k), player_pos.x);
        report_test("walk right", errs);

        errs = errors;
        send_key(key_up, 1'b0);
        guard = 0;
        while (motion != rising && guard < 4 * `SNOW_TICK_CYCLES) begin
            @(negedge clk);
            guard++;
        end
        assert (motion == rising) else begin
            $display("jump did not start after up was pressed");
            errors++;
        end
        send_key(key_up, 1'b1);
        min_y = player_pos.y;
        saw_falling = 1'b0;
        guard = 0;
        while (!(saw_falling && motion == on_ground) && guard < 400 * `SNOW_TICK_CYCLES) begin
            @(negedge clk);
            guard++;
            if (int'(player_pos.y) < min_y)
                min_y = player_pos.y;
            if (motion == falling)
                saw_falling = 1'b1;
        end
        assert (saw_falling && motion == on_ground) else begin
            $display("player did not fall and land after the jump");
            errors++;
        end
        check_value("peak y", `SNOW_SPAWN_Y - peak_rise(), min_y);
        check_value("landing y", `SNOW_SPAWN_Y, player_pos.y);
        report_test("jump", errs);

        errs = errors;
        walk_to(key_right, walk_far);
        repeat (4) @(negedge clk);
        first_score = count_ones(seen_mask);
        check_value("score after first pass", first_score, score);
        walk_to(key_left, walk_back);
        walk_to(key_right, walk_far);
        repeat (4) @(negedge clk);
        check_value("score after second pass", first_score, score);
        check_value("mask after second pass", int'(seen_mask), int'(flakes));
        report_test("flake pickup", errs);

        errs = errors;
        send_key(key_respawn, 1'b0);
        check_value("ready while respawn waits", 0, key_ready);
        guard = 0;
        while (!key_ready && guard < 2 * `SNOW_TICK_CYCLES) begin
            @(negedge clk);
            guard++;
        end
        check_range("cycles until ready returns", 1, `SNOW_TICK_CYCLES, guard);
        check_value("respawn x", `SNOW_SPAWN_X, player_pos.x);
        check_value("respawn y", `SNOW_SPAWN_Y, player_pos.y);
        check_value("respawn motion", int'(on_ground), int'(motion));
        report_test("respawn", errs);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
module tb_clock (
    output logic clk_o
);

    // period of 4 time units
    initial clk_o = 1'b0;
    always #2 clk_o = ~clk_o;

endmodule

/* source/snow_game_top.sv */
`include "snow_consts.svh"

module snow_game_top
    import snow_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_i,
    input  key_event_t                 key_event_i,
    input  logic                       key_valid_i,
    output logic                       key_ready_o,
    output pos_t                       player_pos_o,
    output motion_state_e              motion_o,
    output logic [3:0]                 score_o,
    output logic [`SNOW_FLAKE_NUM-1:0] flakes_o
);

    held_keys_t held;
    logic       respawn_req;
    logic       respawn_ack;
    contact_t   contact;

    key_tracker u_keys (
        .clk           (clk),
        .rst_i         (rst_i),
        .key_event_i   (key_event_i),
        .key_valid_i   (key_valid_i),
        .key_ready_o   (key_ready_o),
        .respawn_ack_i (respawn_ack),
        .held_o        (held),
        .respawn_req_o (respawn_req)
    );

    block_collision u_coll (
        .clk       (clk),
        .rst_i     (rst_i),
        .pos_i     (player_pos_o),
        .contact_o (contact)
    );

    player_motion u_motion (
        .clk           (clk),
        .rst_i         (rst_i),
        .held_i        (held),
        .respawn_req_i (respawn_req),
        .respawn_ack_o (respawn_ack),
        .contact_i     (contact),
        .pos_o         (player_pos_o),
        .motion_o      (motion_o)
    );

    pickup_tracker u_pickup (
        .clk      (clk),
        .rst_i    (rst_i),
        .pos_i    (player_pos_o),
        .score_o  (score_o),
        .flakes_o (flakes_o)
    );

endmodule

/* source/pickup_tracker.sv */
`include "snow_consts.svh"

module pickup_tracker
    import snow_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_i,
    input  pos_t                       pos_i,
    output logic [3:0]                 score_o,
    output logic [`SNOW_FLAKE_NUM-1:0] flakes_o
);

    logic [`SNOW_FLAKE_NUM-1:0] hit;
    logic [`SNOW_FLAKE_NUM-1:0] new_hits;
    logic [3:0]                 new_cnt;
    logic [10:0]                px_hi;
    logic [9:0]                 py_hi;

    assign px_hi = {1'b0, pos_i.x} + 11'(`SNOW_PLAYER_W - 1);
    assign py_hi = {1'b0, pos_i.y} + 10'(`SNOW_PLAYER_H - 1);

    for (genvar g = 0; g < `SNOW_FLAKE_NUM; g++) begin : gen_flake
        localparam pos_t flk = flake_pos(g);
        localparam logic [10:0] fx_hi = 11'(flk.x + `SNOW_FLAKE_W - 1);
        localparam logic [9:0] fy_hi = 10'(flk.y + `SNOW_FLAKE_H - 1);

        // one shared pixel is enough
        assign hit[g] = ({1'b0, pos_i.x} <= fx_hi) && (px_hi >= 11'(flk.x))
                     && ({1'b0, pos_i.y} <= fy_hi) && (py_hi >= 10'(flk.y));
    end

    assign new_hits = hit & ~flakes_o;

    always_comb begin
        new_cnt = '0;
        for (int k = 0; k < `SNOW_FLAKE_NUM; k++)
            new_cnt = new_cnt + 4'(new_hits[k]);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            flakes_o <= '0;
            score_o  <= '0;
        end else begin
            flakes_o <= flakes_o | hit;
            score_o  <= score_o + new_cnt;
        end
    end

    a_score_matches_mask: assert property (
        @(posedge clk) disable iff (rst_i)
        int'(score_o) == $countones(flakes_o)
    );

endmodule

/* source/player_motion.sv */
`include "snow_consts.svh"

module player_motion
    import snow_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  held_keys_t    held_i,
    input  logic          respawn_req_i,
    output logic          respawn_ack_o,
    input  contact_t      contact_i,
    output pos_t          pos_o,
    output motion_state_e motion_o
);

    localparam int tw = $clog2(`SNOW_TICK_CYCLES);
    localparam int hw = $clog2(`SNOW_MOVE_TICKS);

    logic [tw-1:0] tick_cnt;
    logic          tick;
    logic [hw-1:0] hx_cnt;
    coord_x_t      x_q;
    coord_y_t      y_q;
    motion_state_e state_q;
    logic [3:0]    vy_cnt;
    logic [3:0]    rise_int;
    logic [3:0]    fall_int;
    logic [1:0]    pix_cnt;
    logic          move_right;
    logic          move_left;

    assign tick = (tick_cnt == tw'(`SNOW_TICK_CYCLES - 1));
    assign respawn_ack_o = tick && respawn_req_i;

    assign move_right = held_i.right && !held_i.left && !contact_i.right;
    // no wrap off the left screen edge
    assign move_left = held_i.left && !held_i.right && !contact_i.left && (x_q != '0);

    assign pos_o = '{x: x_q, y: y_q};
    assign motion_o = state_q;

    always_ff @(posedge clk) begin
        if (rst_i || tick) tick_cnt <= '0;
        else tick_cnt <= tick_cnt + 1'b1;
    end

    // sideways stepping
    always_ff @(posedge clk) begin
        if (rst_i) begin
            x_q    <= coord_x_t'(`SNOW_SPAWN_X);
            hx_cnt <= '0;
        end else if (tick) begin
            if (respawn_req_i) begin
                x_q    <= coord_x_t'(`SNOW_SPAWN_X);
                hx_cnt <= '0;
            end else if (move_right || move_left) begin
                if (hx_cnt == hw'(`SNOW_MOVE_TICKS - 1)) begin
                    hx_cnt <= '0;
                    x_q    <= move_right ? x_q + 1'b1 : x_q - 1'b1;
                end else begin
                    hx_cnt <= hx_cnt + 1'b1;
                end
            end else begin
                hx_cnt <= '0;
            end
        end
    end

    // vertical motion FSM
    always_ff @(posedge clk) begin
        if (rst_i || respawn_ack_o) begin
            state_q  <= on_ground;
            y_q      <= coord_y_t'(`SNOW_SPAWN_Y);
            vy_cnt   <= '0;
            pix_cnt  <= '0;
            rise_int <= 4'(`SNOW_JUMP_START);
            fall_int <= 4'(`SNOW_FALL_START);
        end else if (tick) begin
            case (state_q)
                on_ground: begin
                    vy_cnt  <= '0;
                    pix_cnt <= '0;
                    if (held_i.up && contact_i.below) begin
                        state_q  <= rising;
                        rise_int <= 4'(`SNOW_JUMP_START);
                    end else if (!contact_i.below) begin
                        state_q  <= falling;
                        fall_int <= 4'(`SNOW_FALL_START);
                    end
                end
                rising: begin
                    if (contact_i.above || rise_int >= 4'(`SNOW_JUMP_END)) begin
                        state_q  <= falling;
                        fall_int <= 4'(`SNOW_FALL_START);
                        vy_cnt   <= '0;
                        pix_cnt  <= '0;
                    end else if (vy_cnt == rise_int - 4'd1) begin
                        vy_cnt <= '0;
                        y_q    <= y_q - 1'b1;
                        // slow down as the rise goes on
                        if (pix_cnt == 2'(`SNOW_ACCEL_PIXELS - 1)) begin
                            pix_cnt  <= '0;
                            rise_int <= rise_int + 4'(`SNOW_ACCEL_STEP);
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end else begin
                        vy_cnt <= vy_cnt + 1'b1;
                    end
                end
                falling: begin
                    if (contact_i.below) begin
                        state_q <= on_ground;
                    end else if (vy_cnt == fall_int - 4'd1) begin
                        vy_cnt <= '0;
                        y_q    <= y_q + 1'b1;
                        if (pix_cnt == 2'(`SNOW_ACCEL_PIXELS - 1)) begin
                            pix_cnt <= '0;
                            // speed up, capped at the fastest fall
                            if (fall_int >= 4'(`SNOW_FALL_MIN + `SNOW_ACCEL_STEP))
                                fall_int <= fall_int - 4'(`SNOW_ACCEL_STEP);
                            else
                                fall_int <= 4'(`SNOW_FALL_MIN);
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end else begin
                        vy_cnt <= vy_cnt + 1'b1;
                    end
                end
                default: state_q <= on_ground;
            endcase
        end
    end

    // standing still vertically unless a respawn moves the player
    a_ground_y_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (state_q == on_ground && !respawn_ack_o) |=> $stable(y_q)
    );

endmodule

/* source/block_collision.sv */
`include "snow_consts.svh"

module block_collision
    import snow_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  pos_t     pos_i,
    output contact_t contact_o
);

    logic [`SNOW_BLOCK_NUM-1:0] hit_below;
    logic [`SNOW_BLOCK_NUM-1:0] hit_above;
    logic [`SNOW_BLOCK_NUM-1:0] hit_right;
    logic [`SNOW_BLOCK_NUM-1:0] hit_left;

    // player box edges, widened so the sums cannot wrap
    logic [10:0] px_lo;
    logic [10:0] px_hi;
    logic [9:0]  py_lo;
    logic [9:0]  py_hi;

    assign px_lo = {1'b0, pos_i.x};
    assign px_hi = px_lo + 11'(`SNOW_PLAYER_W - 1);
    assign py_lo = {1'b0, pos_i.y};
    assign py_hi = py_lo + 10'(`SNOW_PLAYER_H - 1);

    for (genvar g = 0; g < `SNOW_BLOCK_NUM; g++) begin : gen_block
        localparam pos_t blk = block_pos(g);
        localparam logic [10:0] bx_lo = 11'(blk.x);
        localparam logic [10:0] bx_hi = 11'(blk.x + `SNOW_BLOCK_W - 1);
        localparam logic [9:0] by_lo = 10'(blk.y);
        localparam logic [9:0] by_hi = 10'(blk.y + `SNOW_BLOCK_H - 1);

        logic x_ov;
        logic y_ov;

        assign x_ov = (px_lo <= bx_hi) && (px_hi >= bx_lo);
        assign y_ov = (py_lo <= by_hi) && (py_hi >= by_lo);

        // touching means the boxes sit one pixel apart on one axis
        assign hit_below[g] = x_ov && (py_hi + 10'd1 == by_lo);
        assign hit_above[g] = x_ov && (py_lo == by_hi + 10'd1);
        assign hit_right[g] = y_ov && (px_hi + 11'd1 == bx_lo);
        assign hit_left[g]  = y_ov && (px_lo == bx_hi + 11'd1);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            contact_o <= '0;
        end else begin
            contact_o.below <= |hit_below;
            contact_o.above <= |hit_above;
            contact_o.right <= |hit_right;
            contact_o.left  <= |hit_left;
        end
    end

endmodule

/* source/key_tracker.sv */
module key_tracker
    import snow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  key_event_t key_event_i,
    input  logic       key_valid_i,
    output logic       key_ready_o,
    input  logic       respawn_ack_i,
    output held_keys_t held_o,
    output logic       respawn_req_o
);

    logic      accept;
    key_code_e code;

    assign accept = key_valid_i && key_ready_o;
    assign code = key_code_e'(key_event_i.code);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            held_o        <= '0;
            respawn_req_o <= 1'b0;
            key_ready_o   <= 1'b1;
        end else if (accept) begin
            // press sets, release clears, only for the key named
            case (code)
                key_up:    held_o.up    <= !key_event_i.is_release;
                key_left:  held_o.left  <= !key_event_i.is_release;
                key_right: held_o.right <= !key_event_i.is_release;
                key_respawn: begin
                    if (!key_event_i.is_release) begin
                        respawn_req_o <= 1'b1;
                        key_ready_o   <= 1'b0;
                    end
                end
                // down and unknown codes do nothing here
                default: begin
                end
            endcase
        end else if (respawn_ack_i) begin
            // stall ends once the physics tick has moved the player
            respawn_req_o <= 1'b0;
            key_ready_o   <= 1'b1;
        end
    end

    // a pending respawn always blocks new events
    a_req_blocks_ready: assert property (
        @(posedge clk) disable iff (rst_i)
        !(respawn_req_o && key_ready_o)
    );

endmodule

/* source/snow_pkg.sv */
package snow_pkg;

    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } pos_t;

    typedef struct packed {
        logic [7:0] code;
        logic       is_release;
    } key_event_t;

    typedef enum logic [7:0] {
        key_up      = 8'h1D,
        key_left    = 8'h1C,
        key_down    = 8'h1B,
        key_right   = 8'h23,
        key_respawn = 8'h2D
    } key_code_e;

    typedef struct packed {
        logic up;
        logic left;
        logic right;
    } held_keys_t;

    typedef struct packed {
        logic below;
        logic above;
        logic right;
        logic left;
    } contact_t;

    typedef enum logic [1:0] {
        on_ground,
        rising,
        falling
    } motion_state_e;

    // ground row, two middle ledges, one upper ledge
    function automatic pos_t block_pos(input int i);
        pos_t p;
        if (i < 22) begin
            p.x = coord_x_t'(25 * i);
            p.y = coord_y_t'(400);
        end else if (i < 29) begin
            p.x = coord_x_t'(100 + 25 * (i - 22));
            p.y = coord_y_t'(310);
        end else if (i < 36) begin
            p.x = coord_x_t'(300 + 25 * (i - 29));
            p.y = coord_y_t'(310);
        end else begin
            p.x = coord_x_t'(200 + 25 * (i - 36));
            p.y = coord_y_t'(230);
        end
        return p;
    endfunction

    // flakes stack in one column
    function automatic pos_t flake_pos(input int i);
        pos_t p;
        p.x = coord_x_t'(144);
        p.y = coord_y_t'(26 * i);
        return p;
    endfunction

endpackage

/* include/snow_consts.svh */
`ifndef SNOW_CONSTS_SVH
`define SNOW_CONSTS_SVH

// map contents
`define SNOW_BLOCK_NUM 50
`define SNOW_FLAKE_NUM 15

// sprite boxes in pixels
`define SNOW_BLOCK_W 28
`define SNOW_BLOCK_H 42
`define SNOW_PLAYER_W 46
`define SNOW_PLAYER_H 33
`define SNOW_FLAKE_W 24
`define SNOW_FLAKE_H 26

// player rests on the ground row here
`define SNOW_SPAWN_X 0
`define SNOW_SPAWN_Y 367

// clock cycles per physics tick
`define SNOW_TICK_CYCLES 4

// ticks per pixel, sideways
`define SNOW_MOVE_TICKS 4

// ticks per pixel while rising and falling
`define SNOW_JUMP_START 2
`define SNOW_JUMP_END 8
`define SNOW_FALL_START 8
`define SNOW_FALL_MIN 2

// interval changes by this much every few pixels
`define SNOW_ACCEL_STEP 2
`define SNOW_ACCEL_PIXELS 3

`endif
